// File: src/corr_defines.svh
`ifndef CORR_DEFINES_SVH
`define CORR_DEFINES_SVH

// samples per correlation block, power of two
`define CORR_LEN 16
// signed I and Q sample width
`define IN_W 4
// sum width grows by one bit per adder level
`define OUT_W (`IN_W + $clog2(`CORR_LEN))
// saturating overrun counter width
`define CNT_W 8

`endif

// File: src/corr_pkg.sv
`include "corr_defines.svh"

package corr_pkg;

  // one incoming chip period
  typedef struct packed {
    logic signed [`IN_W-1:0] i;
    logic signed [`IN_W-1:0] q;
    // spreading code chip, 1 means invert
    logic                    chip;
    // first sample of a block
    logic                    sof;
  } iq_sample_t;

  // strobes from the control block to the core
  typedef struct packed {
    logic we;
    logic data_latch;
    logic we_adder;
  } corr_ctrl_t;

  // one despread block
  typedef struct packed {
    logic signed [`OUT_W-1:0] i;
    logic signed [`OUT_W-1:0] q;
  } corr_result_t;

  // block synchronization
  typedef enum logic {
    SYNC_WAIT,
    COLLECT
  } ctl_state_t;

  // four-phase sender
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQ,
    PORT_RELEASE
  } port_state_t;

endpackage

// File: src/piped_adder.sv
`timescale 1ns/1ps

module piped_adder #(
  parameter int N_ARGS = 16,
  parameter int ARG_W  = 4
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   we,
  input  logic [N_ARGS-1:0][ARG_W-1:0]           args_in,
  output logic signed [ARG_W+$clog2(N_ARGS)-1:0] sum_out,
  output logic                                   valid
);

  localparam int LVLS = $clog2(N_ARGS);

  // level 0 registers the operands, every later level halves the count
  for (genvar l = 0; l <= LVLS; l++) begin : g_lvl
    localparam int W = ARG_W + l;
    localparam int N = N_ARGS >> l;

    logic signed [W-1:0] node [N];
    logic                vld;

    if (l == 0) begin : g_load
      always_ff @(posedge clk) begin
        if (we) begin
          for (int i = 0; i < N; i++) begin
            node[i] <= $signed(args_in[i]);
          end
        end
      end

      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          vld <= 1'b0;
        end else begin
          vld <= we;
        end
      end
    end else begin : g_add
      // one extra bit per level, so a pair never overflows
      always_ff @(posedge clk) begin
        if (g_lvl[l-1].vld) begin
          for (int i = 0; i < N; i++) begin
            node[i] <= g_lvl[l-1].node[2*i] + g_lvl[l-1].node[2*i+1];
          end
        end
      end

      // valid follows its operands level by level
      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          vld <= 1'b0;
        end else begin
          vld <= g_lvl[l-1].vld;
        end
      end
    end
  end

  assign sum_out = g_lvl[LVLS].node[0];
  assign valid   = g_lvl[LVLS].vld;

endmodule

// File: src/corr_core.sv
`timescale 1ns/1ps
`include "corr_defines.svh"

module corr_core
  import corr_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  iq_sample_t   sample,
  input  corr_ctrl_t   ctrl,
  output corr_result_t sum,
  output logic         sum_valid
);

  // input shift registers, oldest sample at index 0
  logic [`CORR_LEN-1:0][`IN_W-1:0] sh_i;
  logic [`CORR_LEN-1:0][`IN_W-1:0] sh_q;
  logic [`CORR_LEN-1:0]            sh_chip;

  // window as it looks once the incoming sample is in
  logic [`CORR_LEN-1:0][`IN_W-1:0] win_i;
  logic [`CORR_LEN-1:0][`IN_W-1:0] win_q;
  logic [`CORR_LEN-1:0]            win_chip;

  // working copy held while the trees run
  logic [`CORR_LEN-1:0][`IN_W-1:0] wrk_i;
  logic [`CORR_LEN-1:0][`IN_W-1:0] wrk_q;
  logic [`CORR_LEN-1:0]            wrk_chip;

  // sign multiplier outputs
  logic [`CORR_LEN-1:0][`IN_W-1:0] mul_i;
  logic [`CORR_LEN-1:0][`IN_W-1:0] mul_q;

  logic signed [`OUT_W-1:0] sum_i;
  logic signed [`OUT_W-1:0] sum_q;

  assign win_i    = {sample.i, sh_i[`CORR_LEN-1:1]};
  assign win_q    = {sample.q, sh_q[`CORR_LEN-1:1]};
  assign win_chip = {sample.chip, sh_chip[`CORR_LEN-1:1]};

  always_ff @(posedge clk) begin
    if (ctrl.we) begin
      sh_i    <= win_i;
      sh_q    <= win_q;
      sh_chip <= win_chip;
    end
  end

  // last sample of the block goes straight into the working window
  always_ff @(posedge clk) begin
    if (ctrl.data_latch) begin
      wrk_i    <= win_i;
      wrk_q    <= win_q;
      wrk_chip <= win_chip;
    end
  end

  // chip 1 negates the sample
  // negating the most negative value wraps back to itself, as IN_W bits
  for (genvar k = 0; k < `CORR_LEN; k++) begin : g_mul
    assign mul_i[k] = wrk_chip[k] ? -$signed(wrk_i[k]) : $signed(wrk_i[k]);
    assign mul_q[k] = wrk_chip[k] ? -$signed(wrk_q[k]) : $signed(wrk_q[k]);
  end

  piped_adder #(
    .N_ARGS (`CORR_LEN),
    .ARG_W  (`IN_W)
  ) u_sum_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (ctrl.we_adder),
    .args_in (mul_i),
    .sum_out (sum_i),
    .valid   (sum_valid)
  );

  // same timing as the I tree, so its valid is not needed
  piped_adder #(
    .N_ARGS (`CORR_LEN),
    .ARG_W  (`IN_W)
  ) u_sum_q (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (ctrl.we_adder),
    .args_in (mul_q),
    .sum_out (sum_q),
    .valid   ()
  );

  assign sum.i = sum_i;
  assign sum.q = sum_q;

endmodule

// File: src/corr_ctrl.sv
`timescale 1ns/1ps
`include "corr_defines.svh"

module corr_ctrl
  import corr_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sample_valid,
  input  logic       sof,
  output corr_ctrl_t ctrl
);

  // counter wraps to zero exactly at CORR_LEN
  localparam int CW = $clog2(`CORR_LEN);

  ctl_state_t    state;
  logic [CW-1:0] chip_cnt;
  logic          last_chip;
  logic          we_adder_q;

  // block completes on its CORR_LEN-th accepted sample
  assign last_chip = sample_valid && !sof && (state == COLLECT) &&
                     (chip_cnt == CW'(`CORR_LEN - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= SYNC_WAIT;
      chip_cnt <= '0;
    end else begin
      case (state)
        SYNC_WAIT: begin
          // nothing counts before the first sof
          if (sample_valid && sof) begin
            state    <= COLLECT;
            chip_cnt <= CW'(1);
          end
        end
        COLLECT: begin
          if (sample_valid) begin
            if (sof) begin
              // resync, partial block is discarded
              chip_cnt <= CW'(1);
            end else if (last_chip) begin
              chip_cnt <= '0;
            end else begin
              chip_cnt <= chip_cnt + 1'b1;
            end
          end
        end
        default: begin
          state    <= SYNC_WAIT;
          chip_cnt <= '0;
        end
      endcase
    end
  end

  // adder starts one cycle after the window is latched
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      we_adder_q <= 1'b0;
    end else begin
      we_adder_q <= last_chip;
    end
  end

  assign ctrl.we         = sample_valid;
  assign ctrl.data_latch = last_chip;
  assign ctrl.we_adder   = we_adder_q;

endmodule

// File: src/result_port.sv
`timescale 1ns/1ps
`include "corr_defines.svh"

module result_port
  import corr_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  corr_result_t      sum,
  input  logic              sum_valid,
  input  logic              ack,
  output corr_result_t      result,
  output logic              req,
  output logic [`CNT_W-1:0] overrun_count
);

  port_state_t state;
  logic        capture;
  logic        drop;

  assign capture = sum_valid && (state == PORT_IDLE);
  assign drop    = sum_valid && (state != PORT_IDLE);

  // held for the whole handshake
  always_ff @(posedge clk) begin
    if (capture) begin
      result <= sum;
    end
  end

  // req up, ack up, req down, ack down
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= PORT_IDLE;
      req   <= 1'b0;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (sum_valid) begin
            state <= PORT_REQ;
            req   <= 1'b1;
          end
        end
        PORT_REQ: begin
          if (ack) begin
            state <= PORT_RELEASE;
            req   <= 1'b0;
          end
        end
        PORT_RELEASE: begin
          // wait for the consumer to let go
          if (!ack) begin
            state <= PORT_IDLE;
          end
        end
        default: begin
          state <= PORT_IDLE;
          req   <= 1'b0;
        end
      endcase
    end
  end

  // results that find the port busy, saturating
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      overrun_count <= '0;
    end else if (drop && (overrun_count != '1)) begin
      overrun_count <= overrun_count + 1'b1;
    end
  end

endmodule

// File: src/despreader_top.sv
`timescale 1ns/1ps
`include "corr_defines.svh"

module despreader_top
  import corr_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  iq_sample_t        sample,
  input  logic              sample_valid,
  input  logic              ack,
  output corr_result_t      result,
  output logic              req,
  output logic [`CNT_W-1:0] overrun_count
);

  corr_ctrl_t   ctrl;
  corr_result_t sum;
  logic         sum_valid;

  // block sync and strobe generation
  corr_ctrl u_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .sample_valid (sample_valid),
    .sof          (sample.sof),
    .ctrl         (ctrl)
  );

  // window, sign multiply and adder trees
  corr_core u_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .sample    (sample),
    .ctrl      (ctrl),
    .sum       (sum),
    .sum_valid (sum_valid)
  );

  // four-phase output towards the consumer
  result_port u_port (
    .clk           (clk),
    .arst_n        (arst_n),
    .sum           (sum),
    .sum_valid     (sum_valid),
    .ack           (ack),
    .result        (result),
    .req           (req),
    .overrun_count (overrun_count)
  );

endmodule

// File: test/corr_checker.sv
`timescale 1ns/1ps
`include "corr_defines.svh"

module corr_checker
  import corr_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  iq_sample_t        sample,
  input  logic              sample_valid,
  input  corr_ctrl_t        ctrl,
  input  logic              ack,
  input  corr_result_t      result,
  input  logic              req,
  input  logic [`CNT_W-1:0] overrun_count,
  output int                err_count,
  output int                checked_count,
  output int                pending
);

  // last strobe edge to req rise
  localparam int LAT     = 2 + $clog2(`CORR_LEN);
  localparam int CNT_MAX = (1 << `CNT_W) - 1;

  int           cyc = 0;
  bit           collecting = 1'b0;
  int           chip_no = 0;
  int           acc_i = 0;
  int           acc_q = 0;
  bit           latch_q = 1'b0;
  bit           req_q = 1'b0;
  bit           ack_q = 1'b0;
  int           drops = 0;
  corr_result_t held;

  // blocks still inside the adder trees
  int due_cyc[$];
  int due_i[$];
  int due_q[$];
  // blocks the port took, waiting for req
  int exp_cyc[$];
  int exp_i[$];
  int exp_q[$];

  initial begin
    err_count     = 0;
    checked_count = 0;
    pending       = 0;
  end

  // product stays IN_W bits wide, so -(-8) comes back as -8
  function automatic int sign_mult(input logic signed [`IN_W-1:0] x, input logic chip);
    int p;
    p = chip ? -int'(x) : int'(x);
    if (p > (1 << (`IN_W - 1)) - 1)
      p = p - (1 << `IN_W);
    return p;
  endfunction

  task automatic report_value(input string name, input int expected, input int got);
    $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, got);
    err_count++;
  endtask

  task automatic report_fault(input string what);
    $display("** Error at %0t: %s", $time, what);
    err_count++;
  endtask

  always @(posedge clk) begin : model
    bit exp_latch;
    if (!arst_n) begin
      if (req)
        report_fault("req is high during reset");
    end else begin
      cyc++;
      exp_latch = 1'b0;
      // block sync on the sampled strobe
      if (sample_valid) begin
        if (sample.sof) begin
          collecting = 1'b1;
          chip_no    = 1;
          acc_i      = sign_mult(sample.i, sample.chip);
          acc_q      = sign_mult(sample.q, sample.chip);
        end else if (collecting) begin
          chip_no++;
          acc_i += sign_mult(sample.i, sample.chip);
          acc_q += sign_mult(sample.q, sample.chip);
          if (chip_no == `CORR_LEN) begin
            exp_latch = 1'b1;
            due_cyc.push_back(cyc + LAT);
            due_i.push_back(acc_i);
            due_q.push_back(acc_q);
            chip_no = 0;
            acc_i   = 0;
            acc_q   = 0;
          end
        end
      end
      if (ctrl.we != sample_valid)
        report_value("ctrl.we", sample_valid, ctrl.we);
      if (ctrl.data_latch != exp_latch)
        report_value("ctrl.data_latch", exp_latch, ctrl.data_latch);
      if (ctrl.we_adder != latch_q)
        report_value("ctrl.we_adder", latch_q, ctrl.we_adder);
      latch_q = exp_latch;
      if (int'(overrun_count) != drops)
        report_value("overrun_count", drops, overrun_count);
      // port is busy until ack was low at the previous edge too
      if (due_cyc.size() > 0 && due_cyc[0] == cyc) begin
        if (!req && !ack_q) begin
          exp_cyc.push_back(due_cyc[0]);
          exp_i.push_back(due_i[0]);
          exp_q.push_back(due_q[0]);
        end else if (drops < CNT_MAX) begin
          drops++;
        end
        void'(due_cyc.pop_front());
        void'(due_i.pop_front());
        void'(due_q.pop_front());
      end
      if (req && !req_q) begin
        if (exp_cyc.size() == 0) begin
          report_fault("req rose with no result expected");
        end else begin
          if (cyc - 1 != exp_cyc[0])
            report_value("req rise cycle", exp_cyc[0], cyc - 1);
          if (int'(result.i) != exp_i[0])
            report_value("result.i", exp_i[0], result.i);
          if (int'(result.q) != exp_q[0])
            report_value("result.q", exp_q[0], result.q);
          checked_count++;
          void'(exp_cyc.pop_front());
          void'(exp_i.pop_front());
          void'(exp_q.pop_front());
        end
        held = result;
      end else if (exp_cyc.size() > 0 && cyc > exp_cyc[0] + 1) begin
        report_fault("req did not rise for a finished block");
        void'(exp_cyc.pop_front());
        void'(exp_i.pop_front());
        void'(exp_q.pop_front());
      end
      if (req && req_q && result != held)
        report_fault("result changed while req was high");
      req_q   = req;
      ack_q   = ack;
      pending = due_cyc.size() + exp_cyc.size();
    end
  end

endmodule

// File: test/tb_despreader.sv
`timescale 1ns/1ps
`include "corr_defines.svh"

module tb_despreader
  import corr_pkg::*;
();

  localparam int REQ_WAIT_MAX = 3000;
  localparam int ACK_WAIT_MAX = 50;
  localparam int DRAIN_MAX    = 600;

  logic              clk;
  logic              arst_n;
  iq_sample_t        sample;
  logic              sample_valid;
  logic              ack;
  corr_result_t      result;
  logic              req;
  logic [`CNT_W-1:0] overrun_count;

  int seed;
  int ack_delay_max = 3;
  int err_count;
  int checked_count;
  int pending;
  int tb_errs;
  int tests_failed;
  int test_no;
  int errs_before;

  logic [`CNT_W-1:0] overruns_before;

  // one block kept so it can be sent again
  logic signed [`IN_W-1:0] blk_i [`CORR_LEN];
  logic signed [`IN_W-1:0] blk_q [`CORR_LEN];
  logic                    blk_chip [`CORR_LEN];

  despreader_top uut (
    .clk           (clk),
    .arst_n        (arst_n),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .ack           (ack),
    .result        (result),
    .req           (req),
    .overrun_count (overrun_count)
  );

  corr_checker chk (
    .clk           (clk),
    .arst_n        (arst_n),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .ctrl          (uut.ctrl),
    .ack           (ack),
    .result        (result),
    .req           (req),
    .overrun_count (overrun_count),
    .err_count     (err_count),
    .checked_count (checked_count),
    .pending       (pending)
  );

  always #2 clk = ~clk;

  task automatic note_failure(input string what);
    $display("** Error at %0t: %s", $time, what);
    tb_errs++;
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fffffff) % n;
  endfunction

  // mode 0 random, 1 chips zero, 2 chips one, 3 full-scale negative, 4 that with chips one
  task automatic fill_block(input int mode);
    int r;
    for (int k = 0; k < `CORR_LEN; k++) begin
      r = $random(seed);
      blk_i[k]    = r[`IN_W-1:0];
      blk_q[k]    = r[2*`IN_W-1:`IN_W];
      blk_chip[k] = r[2*`IN_W];
      if (mode == 1)
        blk_chip[k] = 1'b0;
      if (mode == 2 || mode == 4)
        blk_chip[k] = 1'b1;
      if (mode >= 3) begin
        blk_i[k] = {1'b1, {(`IN_W-1){1'b0}}};
        blk_q[k] = {1'b1, {(`IN_W-1){1'b0}}};
      end
    end
  endtask

  // starts and ends just after a falling edge
  task automatic send_block(input int len, input logic first_sof, input int gap_max);
    for (int k = 0; k < len; k++) begin
      sample.i     = blk_i[k];
      sample.q     = blk_q[k];
      sample.chip  = blk_chip[k];
      sample.sof   = first_sof && (k == 0);
      sample_valid = 1'b1;
      @(negedge clk);
      sample_valid = 1'b0;
      repeat (rand_below(gap_max + 1)) @(negedge clk);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((pending != 0 || req || ack) && n < DRAIN_MAX) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0 || req || ack)
      note_failure("timeout: results did not drain from the port");
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_count + tb_errs - errs_before;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_no, name);
    end else begin
      $display("test %0d %s: %0d errors", test_no, name, errs);
      tests_failed++;
    end
    test_no++;
    errs_before = err_count + tb_errs;
  endtask

  // consumer side of the four-phase port
  initial begin : consumer
    int n;
    ack = 1'b0;
    forever begin
      n = 0;
      while (!req && n < REQ_WAIT_MAX) begin
        @(negedge clk);
        n++;
      end
      if (!req) begin
        note_failure("timeout: consumer waited too long for req");
      end else begin
        repeat (rand_below(ack_delay_max + 1)) @(negedge clk);
        ack = 1'b1;
        n = 0;
        while (req && n < ACK_WAIT_MAX) begin
          @(negedge clk);
          n++;
        end
        if (req)
          note_failure("timeout: req stayed high after ack");
        repeat (rand_below(3)) @(negedge clk);
        ack = 1'b0;
        @(negedge clk);
      end
    end
  end

  initial begin : main
    clk          = 1'b0;
    arst_n       = 1'b0;
    sample       = '0;
    sample_valid = 1'b0;
    seed         = 32'h6916;
    tb_errs      = 0;
    tests_failed = 0;
    test_no      = 1;
    errs_before  = 0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    repeat (4) @(negedge clk);

    for (int b = 0; b < 2; b++) begin
      fill_block(0);
      send_block(`CORR_LEN, 1'b0, 1);
    end
    wait_drain();
    end_test("no sof");

    for (int b = 0; b < 7; b++) begin
      fill_block((b < 3) ? 0 : b - 2);
      send_block(`CORR_LEN, 1'b1, 0);
    end
    wait_drain();
    end_test("back-to-back blocks");

    // same data without and with gaps
    for (int b = 0; b < 3; b++) begin
      fill_block(0);
      send_block(`CORR_LEN, 1'b1, 0);
      send_block(`CORR_LEN, 1'b1, 3);
    end
    wait_drain();
    end_test("gapped strobes");

    for (int b = 0; b < 3; b++) begin
      fill_block(0);
      send_block(1 + rand_below(`CORR_LEN - 1), 1'b1, 1);
      fill_block(0);
      send_block(`CORR_LEN, 1'b1, 1);
    end
    wait_drain();
    end_test("mid-block sof");

    ack_delay_max   = 40;
    overruns_before = overrun_count;
    for (int b = 0; b < 10; b++) begin
      fill_block(0);
      send_block(`CORR_LEN, 1'b1, 0);
    end
    wait_drain();
    ack_delay_max = 3;
    // slow consumer must have made the port drop results
    if (overrun_count == overruns_before)
      note_failure("no result was dropped while the consumer was slow");
    end_test("overrun");

    $display("tests %0d, failed %0d, results checked %0d, errors %0d",
             test_no - 1, tests_failed, checked_count, err_count + tb_errs);
    if (tests_failed == 0 && err_count + tb_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/corr_pkg.sv
src/piped_adder.sv
src/corr_core.sv
src/corr_ctrl.sv
src/result_port.sv
src/despreader_top.sv
test/corr_checker.sv
test/tb_despreader.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the run by its log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_despreader -f vlog.f \
  -o sim_despreader || { echo "build failed"; exit 1; }
./obj_dir/sim_despreader > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "All tests passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
